// ==== src.f ====
+incdir+include
src/ao_periph_pkg.sv
src/ao_bus_ctrl.sv
src/soc_ctrl_regs.sv
src/ao_timer.sv
src/gpio_regs.sv
src/fast_intr_ctrl.sv
src/ao_periph_top.sv
test/tb_ao_periph.sv

// ==== src/ao_bus_ctrl.sv ====
// OBI-style bus front end for the always-on peripherals.
// Grants every request, decodes the target and returns read data one cycle later.
`timescale 1ns/1ps
`default_nettype none

module ao_bus_ctrl
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,

  // Bus from the CPU side
  input  logic     bus_req_i,
  input  addr_t    bus_addr_i,
  input  logic     bus_we_i,
  input  word_t    bus_wdata_i,
  output logic     bus_gnt_o,
  output logic     bus_rvalid_o,
  output word_t    bus_rdata_o,

  // Shared register bus lines
  output logic     reg_we_o,
  output reg_idx_t reg_idx_o,
  output word_t    reg_wdata_o,

  // Per-peripheral strobes
  output logic     soc_sel_o,
  output logic     timer_sel_o,
  output logic     gpio_sel_o,
  output logic     fast_sel_o,

  // Read data back from the peripherals
  input  word_t    soc_rdata_i,
  input  word_t    timer_rdata_i,
  input  word_t    gpio_rdata_i,
  input  word_t    fast_rdata_i
);

  logic        base_hit;
  logic        access;
  periph_sel_t periph_sel;
  word_t       rdata_d;

  // No back-pressure
  assign bus_gnt_o = bus_req_i;

  assign base_hit   = (bus_addr_i[31:16] == AO_BASE);
  assign periph_sel = bus_addr_i[15:12];
  assign access     = bus_req_i & base_hit;

  assign soc_sel_o   = access & (periph_sel == SOC_CTRL_SEL);
  assign timer_sel_o = access & (periph_sel == TIMER_SEL);
  assign gpio_sel_o  = access & (periph_sel == GPIO_SEL);
  assign fast_sel_o  = access & (periph_sel == FAST_INTR_SEL);

  // Shared lines go straight through to every peripheral
  assign reg_we_o    = bus_we_i;
  assign reg_idx_o   = bus_addr_i[3:2];
  assign reg_wdata_o = bus_wdata_i;

  // Read data steering, zero for writes and unmapped addresses
  always_comb begin
    rdata_d = '0;
    if (!bus_we_i) begin
      if (soc_sel_o) begin
        rdata_d = soc_rdata_i;
      end else if (timer_sel_o) begin
        rdata_d = timer_rdata_i;
      end else if (gpio_sel_o) begin
        rdata_d = gpio_rdata_i;
      end else if (fast_sel_o) begin
        rdata_d = fast_rdata_i;
      end
    end
  end

  // Response phase, one cycle after the grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
    end else begin
      bus_rvalid_o <= bus_req_i;
      bus_rdata_o  <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/ao_periph_pkg.sv ====
// Shared types and address map for the always-on peripheral subsystem.
// Imported by the bus controller and the register peripherals.
`default_nettype none

package ao_periph_pkg;

  // Bus data word and byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Register index inside a peripheral, address bits 3:2
  typedef logic [1:0] reg_idx_t;

  // Peripheral field, address bits 15:12
  typedef logic [3:0] periph_sel_t;

  // Peripheral field values, anything else is unmapped
  localparam periph_sel_t SOC_CTRL_SEL  = 4'd0;
  localparam periph_sel_t TIMER_SEL     = 4'd1;
  localparam periph_sel_t GPIO_SEL      = 4'd2;
  localparam periph_sel_t FAST_INTR_SEL = 4'd3;

  // Upper address half shared by every always-on register
  localparam logic [15:0] AO_BASE = 16'h2000;

endpackage

`default_nettype wire

// ==== src/ao_periph_top.sv ====
// Top of the always-on peripheral subsystem.
// Connects the bus controller to the SoC control, timer, GPIO and fast interrupt blocks.
`timescale 1ns/1ps
`default_nettype none

module ao_periph_top
  import ao_periph_pkg::*;
#(
  parameter int unsigned GPIO_W        = 8,
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     bus_req_i,
  input  addr_t                    bus_addr_i,
  input  logic                     bus_we_i,
  input  word_t                    bus_wdata_i,
  output logic                     bus_gnt_o,
  output logic                     bus_rvalid_o,
  output word_t                    bus_rdata_o,

  input  logic                     boot_select_i,
  input  logic                     execute_from_flash_i,
  output logic                     exit_valid_o,
  output word_t                    exit_value_o,

  output logic                     timer_intr_o,

  input  logic [GPIO_W-1:0]        gpio_i,
  output logic [GPIO_W-1:0]        gpio_o,
  output logic [GPIO_W-1:0]        gpio_oe_o,
  output logic [GPIO_W-1:0]        gpio_intr_o,

  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  logic     reg_we;
  reg_idx_t reg_idx;
  word_t    reg_wdata;

  logic     soc_sel;
  logic     timer_sel;
  logic     gpio_sel;
  logic     fast_sel;

  word_t    soc_rdata;
  word_t    timer_rdata;
  word_t    gpio_rdata;
  word_t    fast_rdata;

  ao_bus_ctrl u_bus_ctrl (
    .clk_i,
    .arst_n_i,
    .bus_req_i,
    .bus_addr_i,
    .bus_we_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .reg_we_o      (reg_we),
    .reg_idx_o     (reg_idx),
    .reg_wdata_o   (reg_wdata),
    .soc_sel_o     (soc_sel),
    .timer_sel_o   (timer_sel),
    .gpio_sel_o    (gpio_sel),
    .fast_sel_o    (fast_sel),
    .soc_rdata_i   (soc_rdata),
    .timer_rdata_i (timer_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .fast_rdata_i  (fast_rdata)
  );

  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .sel_i    (soc_sel),
    .we_i     (reg_we),
    .idx_i    (reg_idx),
    .wdata_i  (reg_wdata),
    .rdata_o  (soc_rdata),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer u_timer (
    .clk_i,
    .arst_n_i,
    .sel_i   (timer_sel),
    .we_i    (reg_we),
    .idx_i   (reg_idx),
    .wdata_i (reg_wdata),
    .rdata_o (timer_rdata),
    .intr_o  (timer_intr_o)
  );

  gpio_regs #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .clk_i,
    .arst_n_i,
    .sel_i   (gpio_sel),
    .we_i    (reg_we),
    .idx_i   (reg_idx),
    .wdata_i (reg_wdata),
    .rdata_o (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o
  );

  fast_intr_ctrl #(
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) u_fast_intr (
    .clk_i,
    .arst_n_i,
    .sel_i   (fast_sel),
    .we_i    (reg_we),
    .idx_i   (reg_idx),
    .wdata_i (reg_wdata),
    .rdata_o (fast_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

endmodule

`default_nettype wire

// ==== src/ao_timer.sv ====
// Free-running 32-bit compare timer with a sticky status bit as interrupt.
// Status is cleared by writing 1 to bit 0 of register 3.
`timescale 1ns/1ps
`default_nettype none

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     sel_i,
  input  logic     we_i,
  input  reg_idx_t idx_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  output logic     intr_o
);

  logic  enable;
  word_t count;
  word_t compare;
  logic  status;
  logic  wr;
  logic  hit;

  assign wr  = sel_i & we_i;
  assign hit = enable & (count == compare);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable  <= 1'b0;
      count   <= '0;
      compare <= '0;
    end else begin
      if (wr && idx_i == 2'd0) begin
        enable <= wdata_i[0];
      end
      if (wr && idx_i == 2'd2) begin
        compare <= wdata_i;
      end
      // Software load wins over counting
      if (wr && idx_i == 2'd1) begin
        count <= wdata_i;
      end else if (hit) begin
        count <= '0;
      end else if (enable) begin
        count <= count + 32'd1;
      end
    end
  end

  // Set has priority over the W1C
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status <= 1'b0;
    end else if (hit) begin
      status <= 1'b1;
    end else if (wr && idx_i == 2'd3 && wdata_i[0]) begin
      status <= 1'b0;
    end
  end

  assign intr_o = status;

  always_comb begin
    case (idx_i)
      2'd0:    rdata_o = word_t'(enable);
      2'd1:    rdata_o = count;
      2'd2:    rdata_o = compare;
      default: rdata_o = word_t'(status);
    endcase
  end

endmodule

`default_nettype wire

// ==== src/fast_intr_ctrl.sv ====
// Fast interrupt controller: sticky pending bits with W1C and an enable mask.
`timescale 1ns/1ps
`default_nettype none

module fast_intr_ctrl
  import ao_periph_pkg::*;
#(
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     sel_i,
  input  logic                     we_i,
  input  reg_idx_t                 idx_i,
  input  word_t                    wdata_i,
  output word_t                    rdata_o,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  logic [NUM_FAST_INTR-1:0] pending;
  logic [NUM_FAST_INTR-1:0] enable;
  logic [NUM_FAST_INTR-1:0] clr_mask;

  assign clr_mask = (sel_i && we_i && idx_i == 2'd0) ? wdata_i[NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending <= '0;
      enable  <= '0;
    end else begin
      // A line seen high beats a clear in the same cycle
      pending <= (pending & ~clr_mask) | fast_intr_i;
      if (sel_i && we_i && idx_i == 2'd1) begin
        enable <= wdata_i[NUM_FAST_INTR-1:0];
      end
    end
  end

  assign fast_intr_o = pending & enable;

  always_comb begin
    case (idx_i)
      2'd0:    rdata_o = word_t'(pending);
      2'd1:    rdata_o = word_t'(enable);
      default: rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/gpio_regs.sv ====
// GPIO block with output, output enable, synchronized input and level interrupts.
// Pin interrupts follow the synchronized input masked by the enable register.
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
  import ao_periph_pkg::*;
#(
  parameter int unsigned GPIO_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              sel_i,
  input  logic              we_i,
  input  reg_idx_t          idx_i,
  input  word_t             wdata_i,
  output word_t             rdata_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o,
  output logic [GPIO_W-1:0] gpio_intr_o
);

  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [GPIO_W-1:0] intr_en;
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
      intr_en  <= '0;
    end else if (sel_i && we_i) begin
      case (idx_i)
        2'd0: gpio_out <= wdata_i[GPIO_W-1:0];
        2'd1: gpio_oe  <= wdata_i[GPIO_W-1:0];
        2'd3: intr_en  <= wdata_i[GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_i;
      in_sync <= in_meta;
    end
  end

  assign gpio_o      = gpio_out;
  assign gpio_oe_o   = gpio_oe;
  assign gpio_intr_o = in_sync & intr_en;

  always_comb begin
    case (idx_i)
      2'd0:    rdata_o = word_t'(gpio_out);
      2'd1:    rdata_o = word_t'(gpio_oe);
      2'd2:    rdata_o = word_t'(in_sync);
      default: rdata_o = word_t'(intr_en);
    endcase
  end

endmodule

`default_nettype wire

// ==== src/soc_ctrl_regs.sv ====
// SoC control registers: exit reporting, boot strap readback and a scratch word.
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_regs
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     sel_i,
  input  logic     we_i,
  input  reg_idx_t idx_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  input  logic     boot_select_i,
  input  logic     execute_from_flash_i,
  output logic     exit_valid_o,
  output word_t    exit_value_o
);

  word_t scratch;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      scratch      <= '0;
    end else if (sel_i && we_i) begin
      case (idx_i)
        2'd0: exit_valid_o <= wdata_i[0];
        2'd1: exit_value_o <= wdata_i;
        2'd3: scratch      <= wdata_i;
        // Straps are read-only
        default: ;
      endcase
    end
  end

  always_comb begin
    case (idx_i)
      2'd0:    rdata_o = word_t'(exit_valid_o);
      2'd1:    rdata_o = exit_value_o;
      2'd2:    rdata_o = word_t'({execute_from_flash_i, boot_select_i});
      default: rdata_o = scratch;
    endcase
  end

endmodule

`default_nettype wire

// ==== include/tb_bus_tasks.svh ====
// Bus access tasks and the random data source for the always-on peripheral testbench.
// Included inside the testbench module after its signal declarations.
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Byte address of one register in one peripheral
function automatic addr_t reg_addr(input periph_sel_t periph, input reg_idx_t idx);
  return {AO_BASE, periph, 8'h00, idx, 2'b00};
endfunction

// One bus cycle; returns the response belonging to the previous cycle
task automatic bus_cycle(input logic req, input logic we, input addr_t addr,
                         input word_t wdata, output word_t rsp);
  @(posedge clk_i);
  bus_req_i   <= req;
  bus_we_i    <= we;
  bus_addr_i  <= addr;
  bus_wdata_i <= wdata;
  @(negedge clk_i);
  if (req) begin
    assert (bus_gnt_o) else fail_value("gnt low in request cycle");
  end
  assert (bus_rvalid_o == req_prev)
    else fail_value($sformatf("rvalid is %0b, expected %0b", bus_rvalid_o, req_prev));
  if (req_prev && we_prev) begin
    assert (bus_rdata_o == '0)
      else fail_value($sformatf("write response rdata is %h", bus_rdata_o));
  end
  rsp      = bus_rdata_o;
  req_prev = req;
  we_prev  = req & we;
endtask

task automatic bus_write(input addr_t addr, input word_t data);
  word_t rsp;
  bus_cycle(1'b1, 1'b1, addr, data, rsp);
  bus_cycle(1'b0, 1'b0, '0, '0, rsp);
endtask

task automatic bus_read(input addr_t addr, output word_t data);
  bus_cycle(1'b1, 1'b0, addr, '0, data);
  bus_cycle(1'b0, 1'b0, '0, '0, data);
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic word_t lfsr_bits(input int unsigned nbits);
  word_t val;
  val = '0;
  for (int unsigned i = 0; i < nbits; i++) begin
    val        = {val[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return val;
endfunction

`endif

// ==== test/tb_ao_periph.sv ====
// Testbench for the always-on peripheral subsystem.
// Walks the bus timing, SoC control, timer, GPIO and fast interrupt behavior.
`timescale 1ns/1ps
`default_nettype none

module tb_ao_periph
  import ao_periph_pkg::*;
();

  localparam int unsigned GPIO_W        = 8;
  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned TIMER_WAIT    = 100;

  logic                     clk_i = 1'b0;
  logic                     arst_n_i;
  logic                     bus_req_i;
  addr_t                    bus_addr_i;
  logic                     bus_we_i;
  word_t                    bus_wdata_i;
  logic                     bus_gnt_o;
  logic                     bus_rvalid_o;
  word_t                    bus_rdata_o;
  logic                     boot_select_i;
  logic                     execute_from_flash_i;
  logic                     exit_valid_o;
  word_t                    exit_value_o;
  logic                     timer_intr_o;
  logic [GPIO_W-1:0]        gpio_i;
  logic [GPIO_W-1:0]        gpio_o;
  logic [GPIO_W-1:0]        gpio_oe_o;
  logic [GPIO_W-1:0]        gpio_intr_o;
  logic [NUM_FAST_INTR-1:0] fast_intr_i;
  logic [NUM_FAST_INTR-1:0] fast_intr_o;

  // Request and write flag of the previous bus cycle
  logic  req_prev;
  logic  we_prev;
  word_t lfsr_state;

  always #10 clk_i = ~clk_i;

  ao_periph_top #(
    .GPIO_W        (GPIO_W),
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) u_dut (.*);

  task automatic fail_value(input string msg);
    $display("FAIL %0t %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("sim failed");
    $fatal(1, "stopping after timeout");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    assert (got == exp) else fail_value($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

`include "tb_bus_tasks.svh"

  initial begin
    word_t                    scratch_w [4];
    word_t                    rsp;
    word_t                    exit_w;
    logic [GPIO_W-1:0]        g_out;
    logic [GPIO_W-1:0]        g_oe;
    logic [GPIO_W-1:0]        g_in;
    logic [GPIO_W-1:0]        g_ie;
    logic [NUM_FAST_INTR-1:0] f_en;
    logic [NUM_FAST_INTR-1:0] f_lines;
    int unsigned              n;

    arst_n_i             = 1'b0;
    bus_req_i            = 1'b0;
    bus_addr_i           = '0;
    bus_we_i             = 1'b0;
    bus_wdata_i          = '0;
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b0;
    gpio_i               = '0;
    fast_intr_i          = '0;
    req_prev             = 1'b0;
    we_prev              = 1'b0;
    lfsr_state           = 32'd16;

    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!bus_rvalid_o && !exit_valid_o && !timer_intr_o)
      else fail_value("rvalid, exit valid or timer interrupt high after reset");
    assert (gpio_oe_o == '0 && gpio_intr_o == '0 && fast_intr_o == '0)
      else fail_value("GPIO or fast interrupt outputs not low after reset");

    // Write then read the scratch word, one request every cycle
    for (n = 0; n < 4; n++) begin
      scratch_w[n] = lfsr_bits(32);
    end
    for (n = 0; n < 4; n++) begin
      bus_cycle(1'b1, 1'b1, reg_addr(SOC_CTRL_SEL, 2'd3), scratch_w[n], rsp);
      if (n > 0) begin
        check_word(rsp, scratch_w[n-1], "scratch readback");
      end
      bus_cycle(1'b1, 1'b0, reg_addr(SOC_CTRL_SEL, 2'd3), '0, rsp);
    end
    bus_cycle(1'b0, 1'b0, '0, '0, rsp);
    check_word(rsp, scratch_w[3], "scratch readback");

    bus_read(reg_addr(4'd7, 2'd3), rsp);
    check_word(rsp, '0, "unmapped peripheral read");
    bus_write(32'h2001_000c, 32'hffff_ffff);
    bus_read(32'h2001_000c, rsp);
    check_word(rsp, '0, "wrong base read");
    bus_read(reg_addr(SOC_CTRL_SEL, 2'd3), rsp);
    check_word(rsp, scratch_w[3], "scratch after wrong base write");

    exit_w = lfsr_bits(32);
    bus_write(reg_addr(SOC_CTRL_SEL, 2'd1), exit_w);
    bus_write(reg_addr(SOC_CTRL_SEL, 2'd0), 32'd1);
    check_word(exit_value_o, exit_w, "exit_value_o");
    assert (exit_valid_o) else fail_value("exit_valid_o low after write");
    @(posedge clk_i);
    boot_select_i        <= 1'b1;
    execute_from_flash_i <= 1'b0;
    bus_read(reg_addr(SOC_CTRL_SEL, 2'd2), rsp);
    check_word(rsp, 32'd1, "strap readback");
    @(posedge clk_i);
    boot_select_i        <= 1'b0;
    execute_from_flash_i <= 1'b1;
    bus_read(reg_addr(SOC_CTRL_SEL, 2'd2), rsp);
    check_word(rsp, 32'd2, "strap readback");

    bus_write(reg_addr(TIMER_SEL, 2'd2), 32'd20);
    bus_write(reg_addr(TIMER_SEL, 2'd0), 32'd1);
    n = 0;
    while (!timer_intr_o) begin
      if (n == TIMER_WAIT) begin
        fail_timeout("the timer interrupt");
      end
      @(negedge clk_i);
      n++;
    end
    bus_read(reg_addr(TIMER_SEL, 2'd3), rsp);
    check_word(rsp, 32'd1, "timer status");
    bus_write(reg_addr(TIMER_SEL, 2'd3), 32'd1);
    assert (!timer_intr_o) else fail_value("timer_intr_o high after status clear");
    bus_read(reg_addr(TIMER_SEL, 2'd3), rsp);
    check_word(rsp, 32'd0, "timer status after clear");
    bus_write(reg_addr(TIMER_SEL, 2'd0), 32'd0);

    g_out = GPIO_W'(lfsr_bits(GPIO_W));
    g_oe  = GPIO_W'(lfsr_bits(GPIO_W));
    g_in  = GPIO_W'(lfsr_bits(GPIO_W));
    g_ie  = GPIO_W'(lfsr_bits(GPIO_W));
    bus_write(reg_addr(GPIO_SEL, 2'd0), word_t'(g_out));
    bus_write(reg_addr(GPIO_SEL, 2'd1), word_t'(g_oe));
    bus_write(reg_addr(GPIO_SEL, 2'd3), word_t'(g_ie));
    assert (gpio_o == g_out && gpio_oe_o == g_oe)
      else fail_value($sformatf("gpio_o %h gpio_oe_o %h, expected %h %h",
                                gpio_o, gpio_oe_o, g_out, g_oe));
    @(posedge clk_i);
    gpio_i <= g_in;
    // Two synchronizer flops plus margin
    repeat (3) @(posedge clk_i);
    bus_read(reg_addr(GPIO_SEL, 2'd2), rsp);
    check_word(rsp, word_t'(g_in), "GPIO input readback");
    check_word(word_t'(gpio_intr_o), word_t'(g_in & g_ie), "gpio_intr_o");

    f_en    = NUM_FAST_INTR'(lfsr_bits(NUM_FAST_INTR));
    f_lines = NUM_FAST_INTR'(lfsr_bits(NUM_FAST_INTR)) | NUM_FAST_INTR'(1);
    bus_write(reg_addr(FAST_INTR_SEL, 2'd1), word_t'(f_en));
    @(posedge clk_i);
    fast_intr_i <= f_lines;
    @(posedge clk_i);
    fast_intr_i <= '0;
    bus_read(reg_addr(FAST_INTR_SEL, 2'd0), rsp);
    check_word(rsp, word_t'(f_lines), "fast interrupt pending");
    check_word(word_t'(fast_intr_o), word_t'(f_lines & f_en), "fast_intr_o");
    bus_write(reg_addr(FAST_INTR_SEL, 2'd0), word_t'(f_lines));
    check_word(word_t'(fast_intr_o), '0, "fast_intr_o after clear");
    bus_read(reg_addr(FAST_INTR_SEL, 2'd0), rsp);
    check_word(rsp, '0, "fast interrupt pending after clear");

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
